/* llcopy_pkg.sv */
package llcopy_pkg;

   // one LocalLink data word
   typedef logic [31:0] word_t;

   // remainder of the last word: 0000 all bytes, 0001 three, 0011 two, 0111 one
   typedef logic [3:0] rem_t;

   // operation flags from header word 4, bits 31:29
   typedef logic [2:0] flags_t;

   // byte length
   typedef logic [31:0] len_t;

   // what a FIFO entry holds
   typedef enum logic [1:0] {
      TAG_FLAGS = 2'd0,
      TAG_LEN   = 2'd1,
      TAG_DATA  = 2'd2,
      TAG_LAST  = 2'd3
   } tag_t;

   // request and completion header layout
   localparam int HDR_WORDS     = 8;
   localparam int HDR_FLAGS_IDX = 4;
   localparam int HDR_LEN_IDX   = 5;

   // 16 entries by default
   localparam int FIFO_AW_DEF = 4;

endpackage

/* ll_frame_parser.sv */
`timescale 1ns/1ps

module ll_frame_parser (
   input  logic               clk,
   input  logic               rst_n,
   input  llcopy_pkg::word_t  tx_d_i,
   input  llcopy_pkg::rem_t   tx_rem_i,
   input  logic               tx_sof_n_i,
   input  logic               tx_eof_n_i,
   input  logic               tx_sop_n_i,
   input  logic               tx_eop_n_i,
   input  logic               tx_src_rdy_n_i,
   input  logic               full_i,
   output logic               tx_dst_rdy_n_o,
   output logic               push_o,
   output llcopy_pkg::tag_t   push_tag_o,
   output llcopy_pkg::word_t  push_data_o,
   output llcopy_pkg::rem_t   push_rem_o
);

   import llcopy_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      HEADER,
      PAYLOAD
   } parse_state_t;

   localparam logic [2:0] HDR_LAST = 3'(HDR_WORDS - 1);

   parse_state_t state_q;
   logic [2:0]   hdr_idx_q;
   logic         rdy_q;
   logic         xfer;
   logic         frame_end;
   logic         in_payload;
   logic         hdr_word;
   logic         is_flags;
   logic         is_len;
   flags_t       flags;

   // held off for a cycle after reset, then only by a full FIFO
   assign tx_dst_rdy_n_o = !rdy_q || full_i;
   assign xfer           = !tx_src_rdy_n_i && !tx_dst_rdy_n_o;
   assign frame_end      = !tx_eop_n_i || !tx_eof_n_i;

   // a start-of-packet inside the header cuts the header short
   assign in_payload = (state_q == PAYLOAD) || (state_q == HEADER && !tx_sop_n_i);
   assign hdr_word   = (state_q == HEADER) && tx_sop_n_i;
   assign is_flags   = hdr_word && (hdr_idx_q == 3'(HDR_FLAGS_IDX));
   assign is_len     = hdr_word && (hdr_idx_q == 3'(HDR_LEN_IDX));
   assign flags      = tx_d_i[31:29];

   assign push_o      = xfer && (is_flags || is_len || in_payload);
   assign push_data_o = is_flags ? word_t'(flags) : tx_d_i;
   assign push_rem_o  = tx_rem_i;

   always_comb begin
      if (is_flags) begin
         push_tag_o = TAG_FLAGS;
      end else if (is_len) begin
         push_tag_o = TAG_LEN;
      end else if (frame_end) begin
         push_tag_o = TAG_LAST;
      end else begin
         push_tag_o = TAG_DATA;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= IDLE;
         hdr_idx_q <= '0;
         rdy_q     <= 1'b0;
      end else begin
         rdy_q <= 1'b1;
         case (state_q)
            IDLE: begin
               // word 0 is taken here
               if (xfer && !tx_sof_n_i) begin
                  state_q   <= HEADER;
                  hdr_idx_q <= 3'd1;
               end
            end
            HEADER: begin
               if (xfer) begin
                  if (in_payload) begin
                     state_q <= frame_end ? IDLE : PAYLOAD;
                  end else begin
                     hdr_idx_q <= hdr_idx_q + 3'd1;
                     if (hdr_idx_q == HDR_LAST) begin
                        state_q <= PAYLOAD;
                     end
                  end
               end
            end
            PAYLOAD: begin
               if (xfer && frame_end) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

/* ll_word_fifo.sv */
`timescale 1ns/1ps

module ll_word_fifo #(
   parameter int AW = llcopy_pkg::FIFO_AW_DEF
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               push_i,
   input  logic               pop_i,
   input  llcopy_pkg::tag_t   push_tag_i,
   input  llcopy_pkg::word_t  push_data_i,
   input  llcopy_pkg::rem_t   push_rem_i,
   output logic               full_o,
   output logic               empty_o,
   output llcopy_pkg::tag_t   head_tag_o,
   output llcopy_pkg::word_t  head_data_o,
   output llcopy_pkg::rem_t   head_rem_o
);

   import llcopy_pkg::*;

   localparam int DEPTH = 1 << AW;

   tag_t          tag_mem  [DEPTH];
   word_t         data_mem [DEPTH];
   rem_t          rem_mem  [DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [AW:0]   count_q;
   logic          do_push;
   logic          do_pop;

   assign full_o  = (count_q == (AW + 1)'(DEPTH));
   assign empty_o = (count_q == '0);
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   assign head_tag_o  = tag_mem[rd_ptr_q];
   assign head_data_o = data_mem[rd_ptr_q];
   assign head_rem_o  = rem_mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (do_push) begin
         tag_mem[wr_ptr_q]  <= push_tag_i;
         data_mem[wr_ptr_q] <= push_data_i;
         rem_mem[wr_ptr_q]  <= push_rem_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // simultaneous push and pop leaves the count alone
         if (do_push && !do_pop) begin
            count_q <= count_q + 1'b1;
         end else if (do_pop && !do_push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

/* ll_completion_framer.sv */
`timescale 1ns/1ps

module ll_completion_framer (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               empty_i,
   input  llcopy_pkg::tag_t   head_tag_i,
   input  llcopy_pkg::word_t  head_data_i,
   input  llcopy_pkg::rem_t   head_rem_i,
   input  logic               rx_dst_rdy_n_i,
   output logic               pop_o,
   output llcopy_pkg::word_t  rx_d_o,
   output llcopy_pkg::rem_t   rx_rem_o,
   output logic               rx_sof_n_o,
   output logic               rx_eof_n_o,
   output logic               rx_sop_n_o,
   output logic               rx_eop_n_o,
   output logic               rx_src_rdy_n_o
);

   import llcopy_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      PAYLOAD,
      HEADER
   } frame_state_t;

   localparam logic [2:0] HDR_LAST = 3'(HDR_WORDS - 1);

   frame_state_t state_q;
   logic [2:0]   hdr_idx_q;
   logic         first_q;
   flags_t       flags_q;
   len_t         req_len_q;
   len_t         byte_cnt_q;
   logic         out_free;
   logic         head_payload;
   logic         head_last;
   logic         pop_field;
   logic         pop_data;
   logic         start_frame;
   logic         hdr_load;
   logic         status;
   word_t        hdr_word;

   // bytes carried by the last word
   function automatic logic [2:0] valid_bytes(input rem_t rem);
      logic [2:0] n;
      case (rem)
         4'b0001: n = 3'd3;
         4'b0011: n = 3'd2;
         4'b0111: n = 3'd1;
         default: n = 3'd4;
      endcase
      return n;
   endfunction

   // output register empty or being taken this cycle
   assign out_free     = rx_src_rdy_n_o || !rx_dst_rdy_n_i;
   assign head_payload = (head_tag_i == TAG_DATA) || (head_tag_i == TAG_LAST);
   assign head_last    = (head_tag_i == TAG_LAST);

   assign pop_field = (state_q == IDLE) && !empty_i &&
                      ((head_tag_i == TAG_FLAGS) || (head_tag_i == TAG_LEN));
   assign pop_data  = (state_q == PAYLOAD) && out_free && !empty_i && head_payload;
   assign pop_o     = pop_field || pop_data;

   // payload without a length entry still starts a frame
   assign start_frame = (state_q == IDLE) && !empty_i &&
                        ((head_tag_i == TAG_LEN) || head_payload);
   assign hdr_load    = (state_q == HEADER) && out_free;

   assign status = (byte_cnt_q == req_len_q);

   always_comb begin
      if (hdr_idx_q == 3'(HDR_FLAGS_IDX)) begin
         hdr_word = {flags_q, status, 28'h0};
      end else if (hdr_idx_q == 3'(HDR_LEN_IDX)) begin
         hdr_word = byte_cnt_q;
      end else begin
         hdr_word = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (pop_field && head_tag_i == TAG_FLAGS) begin
         flags_q <= head_data_i[2:0];
      end
      if (pop_field && head_tag_i == TAG_LEN) begin
         req_len_q <= head_data_i;
      end
      if (start_frame) begin
         byte_cnt_q <= '0;
      end else if (pop_data) begin
         byte_cnt_q <= byte_cnt_q + len_t'(head_last ? valid_bytes(head_rem_i) : 3'd4);
      end
   end

   always_ff @(posedge clk) begin
      if (pop_data) begin
         rx_d_o   <= head_data_i;
         rx_rem_o <= head_last ? head_rem_i : '0;
      end else if (hdr_load) begin
         rx_d_o   <= hdr_word;
         rx_rem_o <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q        <= IDLE;
         hdr_idx_q      <= '0;
         first_q        <= 1'b1;
         rx_src_rdy_n_o <= 1'b1;
         rx_sof_n_o     <= 1'b1;
         rx_eof_n_o     <= 1'b1;
         rx_sop_n_o     <= 1'b1;
         rx_eop_n_o     <= 1'b1;
      end else begin
         // nothing new unless a branch below loads a word
         if (out_free) begin
            rx_src_rdy_n_o <= 1'b1;
            rx_sof_n_o     <= 1'b1;
            rx_eof_n_o     <= 1'b1;
            rx_sop_n_o     <= 1'b1;
            rx_eop_n_o     <= 1'b1;
         end
         case (state_q)
            IDLE: begin
               if (start_frame) begin
                  state_q <= PAYLOAD;
                  first_q <= 1'b1;
               end
            end
            PAYLOAD: begin
               if (pop_data) begin
                  rx_src_rdy_n_o <= 1'b0;
                  rx_sof_n_o     <= !first_q;
                  rx_sop_n_o     <= !first_q;
                  rx_eop_n_o     <= !head_last;
                  first_q        <= 1'b0;
                  if (head_last) begin
                     state_q   <= HEADER;
                     hdr_idx_q <= '0;
                  end
               end
            end
            HEADER: begin
               if (hdr_load) begin
                  rx_src_rdy_n_o <= 1'b0;
                  rx_eof_n_o     <= (hdr_idx_q != HDR_LAST);
                  hdr_idx_q      <= hdr_idx_q + 3'd1;
                  if (hdr_idx_q == HDR_LAST) begin
                     state_q <= IDLE;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

/* ll_copy_engine.sv */
`timescale 1ns/1ps

module ll_copy_engine #(
   parameter int FIFO_AW = llcopy_pkg::FIFO_AW_DEF
) (
   input  logic               clk,
   input  logic               rst_n,
   // transmit port
   input  llcopy_pkg::word_t  tx_d_i,
   input  llcopy_pkg::rem_t   tx_rem_i,
   input  logic               tx_sof_n_i,
   input  logic               tx_eof_n_i,
   input  logic               tx_sop_n_i,
   input  logic               tx_eop_n_i,
   input  logic               tx_src_rdy_n_i,
   output logic               tx_dst_rdy_n_o,
   // receive port
   output llcopy_pkg::word_t  rx_d_o,
   output llcopy_pkg::rem_t   rx_rem_o,
   output logic               rx_sof_n_o,
   output logic               rx_eof_n_o,
   output logic               rx_sop_n_o,
   output logic               rx_eop_n_o,
   output logic               rx_src_rdy_n_o,
   input  logic               rx_dst_rdy_n_i
);

   import llcopy_pkg::*;

   logic  push;
   tag_t  push_tag;
   word_t push_data;
   rem_t  push_rem;
   logic  full;
   logic  pop;
   logic  empty;
   tag_t  head_tag;
   word_t head_data;
   rem_t  head_rem;

   ll_frame_parser ll_frame_parser_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_d_i         (tx_d_i),
      .tx_rem_i       (tx_rem_i),
      .tx_sof_n_i     (tx_sof_n_i),
      .tx_eof_n_i     (tx_eof_n_i),
      .tx_sop_n_i     (tx_sop_n_i),
      .tx_eop_n_i     (tx_eop_n_i),
      .tx_src_rdy_n_i (tx_src_rdy_n_i),
      .full_i         (full),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .push_o         (push),
      .push_tag_o     (push_tag),
      .push_data_o    (push_data),
      .push_rem_o     (push_rem)
   );

   ll_word_fifo #(
      .AW (FIFO_AW)
   ) ll_word_fifo_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .push_i      (push),
      .pop_i       (pop),
      .push_tag_i  (push_tag),
      .push_data_i (push_data),
      .push_rem_i  (push_rem),
      .full_o      (full),
      .empty_o     (empty),
      .head_tag_o  (head_tag),
      .head_data_o (head_data),
      .head_rem_o  (head_rem)
   );

   ll_completion_framer ll_completion_framer_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .empty_i        (empty),
      .head_tag_i     (head_tag),
      .head_data_i    (head_data),
      .head_rem_i     (head_rem),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i),
      .pop_o          (pop),
      .rx_d_o         (rx_d_o),
      .rx_rem_o       (rx_rem_o),
      .rx_sof_n_o     (rx_sof_n_o),
      .rx_eof_n_o     (rx_eof_n_o),
      .rx_sop_n_o     (rx_sop_n_o),
      .rx_eop_n_o     (rx_eop_n_o),
      .rx_src_rdy_n_o (rx_src_rdy_n_o)
   );

endmodule

/* ll_copy_engine_assert.sv */
`timescale 1ns/1ps

module ll_copy_engine_assert (
   input logic              clk,
   input logic              rst_n,
   input llcopy_pkg::word_t rx_d_i,
   input llcopy_pkg::rem_t  rx_rem_i,
   input logic              rx_sof_n_i,
   input logic              rx_eof_n_i,
   input logic              rx_sop_n_i,
   input logic              rx_eop_n_i,
   input logic              rx_src_rdy_n_i,
   input logic              rx_dst_rdy_n_i
);

   // a stalled word stays put until it is taken
   hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      (!rx_src_rdy_n_i && rx_dst_rdy_n_i) |=>
         (!rx_src_rdy_n_i && $stable(rx_d_i) && $stable(rx_rem_i) &&
          $stable({rx_sof_n_i, rx_eof_n_i, rx_sop_n_i, rx_eop_n_i})))
      else $error("receive port changed while stalled");

   // completion header keeps eof away from the first payload word
   no_sof_with_eof: assert property (@(posedge clk) disable iff (!rst_n)
      !(!rx_sof_n_i && !rx_eof_n_i))
      else $error("start and end of frame on the same receive word");

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // low over four rising edges, released on a falling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

/* tb_ll_copy_engine.sv */
`timescale 1ns/1ps

module tb_ll_copy_engine;

   import llcopy_pkg::*;

   localparam int WAIT_LIMIT  = 2000;
   localparam int RAND_FRAMES = 40;
   localparam rem_t REM_CODES [4] = '{4'b0000, 4'b0001, 4'b0011, 4'b0111};

   logic  clk;
   logic  rst_n;
   word_t tx_d;
   rem_t  tx_rem;
   logic  tx_sof_n;
   logic  tx_eof_n;
   logic  tx_sop_n;
   logic  tx_eop_n;
   logic  tx_src_rdy_n;
   logic  tx_dst_rdy_n;
   word_t rx_d;
   rem_t  rx_rem;
   logic  rx_sof_n;
   logic  rx_eof_n;
   logic  rx_sop_n;
   logic  rx_eop_n;
   logic  rx_src_rdy_n;
   logic  rx_dst_rdy_n;

   // expected receive words with ctl as {sof, eof, sop, eop} active low
   word_t      exp_data [$];
   rem_t       exp_rem  [$];
   logic [3:0] exp_ctl  [$];

   logic [31:0] lcg_state;
   string       test_name;
   int          gap_pct;
   int          stall_pct;
   int          tx_held;
   int          mismatches;
   int          timeouts;
   int          failures;
   bit          aborted;

   tb_clock_gen tb_clock_gen_i (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   ll_copy_engine ll_copy_engine_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .tx_d_i         (tx_d),
      .tx_rem_i       (tx_rem),
      .tx_sof_n_i     (tx_sof_n),
      .tx_eof_n_i     (tx_eof_n),
      .tx_sop_n_i     (tx_sop_n),
      .tx_eop_n_i     (tx_eop_n),
      .tx_src_rdy_n_i (tx_src_rdy_n),
      .tx_dst_rdy_n_o (tx_dst_rdy_n),
      .rx_d_o         (rx_d),
      .rx_rem_o       (rx_rem),
      .rx_sof_n_o     (rx_sof_n),
      .rx_eof_n_o     (rx_eof_n),
      .rx_sop_n_o     (rx_sop_n),
      .rx_eop_n_o     (rx_eop_n),
      .rx_src_rdy_n_o (rx_src_rdy_n),
      .rx_dst_rdy_n_i (rx_dst_rdy_n)
   );

   bind ll_copy_engine ll_copy_engine_assert ll_copy_engine_assert_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .rx_d_i         (rx_d_o),
      .rx_rem_i       (rx_rem_o),
      .rx_sof_n_i     (rx_sof_n_o),
      .rx_eof_n_i     (rx_eof_n_o),
      .rx_sop_n_i     (rx_sop_n_o),
      .rx_eop_n_i     (rx_eop_n_o),
      .rx_src_rdy_n_i (rx_src_rdy_n_o),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i)
   );

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = next_random();
      return int'(r[30:8]) % n;
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         mismatches++;
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_rem(input string name, input rem_t exp, input rem_t act);
      if (act !== exp) begin
         mismatches++;
         $display("mismatch %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_strobe(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         mismatches++;
         $display("mismatch %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_rx_idle(input string name);
      check_strobe({name, " rx_src_rdy_n"}, 1'b1, rx_src_rdy_n);
      check_strobe({name, " rx_sof_n"}, 1'b1, rx_sof_n);
      check_strobe({name, " rx_eof_n"}, 1'b1, rx_eof_n);
      check_strobe({name, " rx_sop_n"}, 1'b1, rx_sop_n);
      check_strobe({name, " rx_eop_n"}, 1'b1, rx_eop_n);
   endtask

   task automatic wait_for_reset();
      int cnt;
      cnt = 0;
      do begin
         @(negedge clk);
         // transmit ready may drop once an edge has seen reset released
         if (rst_n !== 1'b1) begin
            check_strobe("reset tx_dst_rdy_n", 1'b1, tx_dst_rdy_n);
         end
         check_rx_idle("reset");
         cnt++;
      end while (rst_n !== 1'b1 && cnt < WAIT_LIMIT);
      if (rst_n !== 1'b1) begin
         timeouts++;
         aborted = 1'b1;
         $display("error: reset was never released");
      end else begin
         @(negedge clk);
         check_rx_idle("after reset");
      end
   endtask

   task automatic send_frame(input int n, input bit match);
      word_t       hdr [HDR_WORDS];
      word_t       pay [12];
      logic [31:0] r;
      flags_t      flags;
      int          ri;
      len_t        count;
      len_t        req_len;
      logic [3:0]  ctl;
      int          total;
      int          wait_cnt;
      bit          sent;
      r       = next_random();
      flags   = r[31:29];
      ri      = rand_below(4);
      count   = len_t'(4 * (n - 1) + (4 - ri));
      req_len = match ? count : count + len_t'(1 + rand_below(7));
      for (int i = 0; i < HDR_WORDS; i++) begin
         hdr[i] = next_random();
      end
      r = next_random();
      hdr[HDR_FLAGS_IDX] = {flags, r[28:0]};
      hdr[HDR_LEN_IDX]   = req_len;
      for (int i = 0; i < n; i++) begin
         pay[i] = next_random();
         ctl    = 4'b1111;
         if (i == 0) begin
            ctl[3] = 1'b0;
            ctl[1] = 1'b0;
         end
         if (i == n - 1) begin
            ctl[0] = 1'b0;
         end
         exp_data.push_back(pay[i]);
         exp_rem.push_back((i == n - 1) ? REM_CODES[ri] : 4'b0000);
         exp_ctl.push_back(ctl);
      end
      // completion words follow the payload
      for (int i = 0; i < HDR_WORDS; i++) begin
         if (i == HDR_FLAGS_IDX) begin
            exp_data.push_back({flags, match, 28'h0});
         end else if (i == HDR_LEN_IDX) begin
            exp_data.push_back(count);
         end else begin
            exp_data.push_back(32'h0);
         end
         exp_rem.push_back(4'b0000);
         exp_ctl.push_back((i == HDR_WORDS - 1) ? 4'b1011 : 4'b1111);
      end
      total = HDR_WORDS + n;
      for (int idx = 0; idx < total && !aborted; idx++) begin
         wait_cnt = 0;
         sent     = 1'b0;
         while (!sent && !aborted) begin
            @(negedge clk);
            if (rand_below(100) < gap_pct) begin
               tx_src_rdy_n = 1'b1;
            end else begin
               tx_d         = (idx < HDR_WORDS) ? hdr[idx] : pay[idx - HDR_WORDS];
               tx_rem       = (idx == total - 1) ? REM_CODES[ri] : 4'b0000;
               tx_sof_n     = (idx != 0);
               tx_sop_n     = (idx != HDR_WORDS);
               tx_eop_n     = (idx != total - 1);
               tx_eof_n     = (idx != total - 1);
               tx_src_rdy_n = 1'b0;
               // ready is steady until the next rising edge
               if (!tx_dst_rdy_n) begin
                  sent = 1'b1;
               end else begin
                  tx_held++;
               end
            end
            wait_cnt++;
            if (!sent && wait_cnt >= WAIT_LIMIT) begin
               timeouts++;
               aborted = 1'b1;
               $display("error: %s transmit port not ready for %0d cycles", test_name, wait_cnt);
            end
         end
      end
   endtask

   task automatic receive_frames(input int n_frames);
      int         frames;
      int         idle;
      logic [3:0] e_ctl;
      frames = 0;
      idle   = 0;
      while (frames < n_frames && !aborted) begin
         @(negedge clk);
         rx_dst_rdy_n = (rand_below(100) < stall_pct);
         if (!rx_dst_rdy_n && !rx_src_rdy_n) begin
            idle = 0;
            if (exp_data.size() == 0) begin
               failures++;
               $display("error: %s receive port sent a word nobody asked for", test_name);
            end else begin
               e_ctl = exp_ctl.pop_front();
               check_word({test_name, " data"}, exp_data.pop_front(), rx_d);
               check_rem({test_name, " rem"}, exp_rem.pop_front(), rx_rem);
               check_strobe({test_name, " sof_n"}, e_ctl[3], rx_sof_n);
               check_strobe({test_name, " eof_n"}, e_ctl[2], rx_eof_n);
               check_strobe({test_name, " sop_n"}, e_ctl[1], rx_sop_n);
               check_strobe({test_name, " eop_n"}, e_ctl[0], rx_eop_n);
               if (!e_ctl[2]) begin
                  frames++;
               end
            end
         end else begin
            idle++;
            if (idle >= WAIT_LIMIT) begin
               timeouts++;
               aborted = 1'b1;
               $display("error: %s receive port idle for %0d cycles", test_name, idle);
            end
         end
      end
      @(negedge clk);
      rx_dst_rdy_n = 1'b1;
   endtask

   // n_words of 0 picks 1 to 12 words
   // match_mode picks mismatch (0), match (1) or random (2)
   task automatic run_phase(input string name, input int n_frames, input int n_words,
                            input int match_mode, input int gap, input int stall);
      int n;
      bit m;
      test_name = name;
      gap_pct   = gap;
      stall_pct = stall;
      fork
         begin
            for (int f = 0; f < n_frames && !aborted; f++) begin
               n = (n_words > 0) ? n_words : 1 + rand_below(12);
               m = (match_mode == 2) ? (rand_below(4) != 0) : (match_mode == 1);
               send_frame(n, m);
            end
            @(negedge clk);
            tx_src_rdy_n = 1'b1;
         end
         receive_frames(n_frames);
      join
   endtask

   initial begin
      tx_d         = '0;
      tx_rem       = '0;
      tx_sof_n     = 1'b1;
      tx_eof_n     = 1'b1;
      tx_sop_n     = 1'b1;
      tx_eop_n     = 1'b1;
      tx_src_rdy_n = 1'b1;
      rx_dst_rdy_n = 1'b1;
      lcg_state    = 32'd94;
      mismatches   = 0;
      timeouts     = 0;
      failures     = 0;
      tx_held      = 0;
      aborted      = 1'b0;
      wait_for_reset();
      run_phase("single", 1, 5, 1, 0, 0);
      run_phase("one word", 1, 1, 1, 0, 0);
      run_phase("mismatch", 1, 3, 0, 0, 0);
      tx_held = 0;
      run_phase("random", RAND_FRAMES, 0, 2, 30, 60);
      if (!aborted && tx_held == 0) begin
         failures++;
         $display("error: transmit ready never dropped under receive back-pressure");
      end
      // nothing may follow the last completion
      rx_dst_rdy_n = 1'b0;
      for (int i = 0; i < 20 && !aborted; i++) begin
         @(negedge clk);
         if (rx_src_rdy_n !== 1'b1) begin
            failures++;
            $display("error: receive port offered a word after the last frame");
         end
      end
      $display("errors: %0d mismatches, %0d timeouts, %0d other failures",
               mismatches, timeouts, failures);
      if (mismatches + timeouts + failures == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
llcopy_pkg.sv
ll_frame_parser.sv
ll_word_fifo.sv
ll_completion_framer.sv
ll_copy_engine.sv
ll_copy_engine_assert.sv
tb_clock_gen.sv
tb_ll_copy_engine.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ll_copy_engine
FILELIST  = verilog.f
PASS_MSG  = sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
